// ==== logic/dmem_out_params.svh ====
`ifndef DMEM_OUT_PARAMS_SVH
`define DMEM_OUT_PARAMS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define DMEM_ADDR_W 32 // HADDR width
`define DMEM_DATA_W 32 // HWDATA width
`define DMEM_PROT_W 4 // HPROT width
`define DMEM_MASTER_W 4 // HMASTER ID width

// ------------------------------
// Port configuration
// ------------------------------
`define DMEM_NPORTS 4 // Input ports sharing this slave
`define DMEM_PORT_W 2 // Bits to index one input port

// Data port after reset; also the round-robin start, so port 0 wins first
`define DMEM_RESET_DPORT 3

`endif

// ==== logic/dmem_out_pkg.sv ====
`default_nettype none

`include "dmem_out_params.svh"

package dmem_out_pkg;

  // ------------------------------
  // AHB encodings
  // ------------------------------
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00, // No transfer
    HTRANS_BUSY   = 2'b01, // Burst pause
    HTRANS_NONSEQ = 2'b10, // First beat
    HTRANS_SEQ    = 2'b11  // Burst continuation
  } htrans_e;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001, // Undefined length
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_e;

  // Arbiter view of the current owner
  typedef enum logic {
    ARB_FREE = 1'b0, // Grant may move on acceptance
    ARB_HELD = 1'b1  // Pinned by burst or lock
  } arb_state_e;

  // ------------------------------
  // One port's address phase, 51 bits
  // ------------------------------
  typedef struct packed {
    logic                      sel;      // HSEL
    logic [`DMEM_ADDR_W-1:0]   addr;     // HADDR
    htrans_e                   trans;    // HTRANS
    logic                      write;    // HWRITE
    logic [2:0]                size;     // HSIZE
    hburst_e                   burst;    // HBURST
    logic [`DMEM_PROT_W-1:0]   prot;     // HPROT
    logic [`DMEM_MASTER_W-1:0] master;   // HMASTER
    logic                      mastlock; // HMASTLOCK
  } ahb_addr_ctrl_t;

  typedef logic [`DMEM_PORT_W-1:0] port_idx_t; // Input port number

endpackage

`default_nettype wire

// ==== logic/dmem_out_arbiter.sv ====
`default_nettype none

`include "dmem_out_params.svh"

module dmem_out_arbiter (
  input  wire                      i_hclk,        // HCLK
  input  wire                      i_hresetn,     // HRESETn, sync
  input  wire  [`DMEM_NPORTS-1:0]  i_held_tran,   // Held transfer per port
  input  wire  [`DMEM_NPORTS-1:0]  i_port_sel,    // HSEL per port
  input  wire                      i_hready,      // Transfer accepted
  input  dmem_out_pkg::htrans_e    i_owner_trans, // HTRANS of granted port
  input  wire                      i_owner_sel,   // HSEL of granted port
  input  wire                      i_hlock_arb,   // Masked lock of owner
  output dmem_out_pkg::port_idx_t  o_grant_port,  // Current address port
  output logic                     o_no_port      // Nobody granted
);

  // ------------------------------
  // Declarations
  // ------------------------------
  logic [`DMEM_NPORTS-1:0]  req;           // Per-port requests
  logic                     burst_cont;    // Owner mid-burst
  dmem_out_pkg::arb_state_e arb_state;     // Held or free this cycle
  dmem_out_pkg::port_idx_t  grant_q;       // Granted port, also RR pointer
  logic                     no_port_q;     // No owner registered
  dmem_out_pkg::port_idx_t  next_port;     // Round-robin winner
  logic                     next_found;    // Any request seen

  // ------------------------------
  // Requests
  // ------------------------------
  // A port asks only when it both holds a transfer and selects us
  assign req = i_held_tran & i_port_sel;

  // SEQ or BUSY from a selected owner continues its burst
  assign burst_cont = i_owner_sel &&
                      (i_owner_trans inside {dmem_out_pkg::HTRANS_SEQ,
                                             dmem_out_pkg::HTRANS_BUSY});

  // Pin decision
  always_comb
  begin
    arb_state = dmem_out_pkg::ARB_FREE;           // Default free
    if (burst_cont || i_hlock_arb)
    begin
      arb_state = dmem_out_pkg::ARB_HELD;         // Burst beat or lock
    end
  end

  // ------------------------------
  // Round-robin search
  // ------------------------------
  // Scan starts one past the last grant, wraps, and ends on the last
  // grant itself so a lone requester can win again
  always_comb
  begin : p_rr_search
    dmem_out_pkg::port_idx_t idx;                 // Candidate port
    idx        = grant_q;
    next_port  = grant_q;                         // Keep pointer if idle
    next_found = 1'b0;
    for (int k = 1; k <= `DMEM_NPORTS; k++)
    begin
      idx = grant_q + dmem_out_pkg::port_idx_t'(k); // Wraps at port count
      if (!next_found && req[idx])
      begin
        next_port  = idx;                         // First in cyclic order
        next_found = 1'b1;
      end
    end
  end

  // ------------------------------
  // Grant register
  // ------------------------------
  always_ff @(posedge i_hclk)
  begin
    if (!i_hresetn)
    begin
      grant_q   <= dmem_out_pkg::port_idx_t'(`DMEM_RESET_DPORT); // Port 0 wins first
      no_port_q <= 1'b1;                          // Idle after reset
    end
    else if (i_hready)                            // Accepting edge only
    begin
      if (arb_state == dmem_out_pkg::ARB_HELD)
      begin
        grant_q   <= grant_q;                     // Owner keeps slave
        no_port_q <= no_port_q;
      end
      else if (next_found)
      begin
        grant_q   <= next_port;                   // New owner
        no_port_q <= 1'b0;
      end
      else
      begin
        no_port_q <= 1'b1;                        // Pointer stays for RR
      end
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign o_grant_port = grant_q;
  assign o_no_port    = no_port_q;

endmodule

`default_nettype wire

// ==== logic/dmem_out_addr_stage.sv ====
`default_nettype none

`include "dmem_out_params.svh"

module dmem_out_addr_stage (
  input  wire                                             i_hclk,       // HCLK
  input  wire                                             i_hresetn,    // HRESETn, sync
  input  dmem_out_pkg::ahb_addr_ctrl_t [`DMEM_NPORTS-1:0] i_port_ac,    // All address phases
  input  dmem_out_pkg::port_idx_t                         i_grant_port, // From arbiter
  input  wire                                             i_no_port,    // From arbiter
  input  wire                                             i_hready,     // HREADYMUXM
  output dmem_out_pkg::ahb_addr_ctrl_t                    o_slave_ac,   // To slave
  output logic [`DMEM_NPORTS-1:0]                         o_active,     // One-hot owner
  output logic                                            o_hlock_arb   // Lock for arbiter
);

  // ------------------------------
  // Declarations
  // ------------------------------
  logic hsel_lock;       // Lock seen while selected
  logic next_hsel_lock;  // Pre-register value

  // ------------------------------
  // Address mux and active decode
  // ------------------------------
  always_comb
  begin
    o_slave_ac = '0;                              // Quiet bus when no owner
    o_active   = '0;
    if (!i_no_port)
    begin
      o_slave_ac             = i_port_ac[i_grant_port]; // Whole bundle at once
      o_active[i_grant_port] = 1'b1;
    end
  end

  // ------------------------------
  // Locked sequence tracking
  // ------------------------------
  // A master may briefly address another region inside a locked
  // sequence; hsel_lock remembers the lock so the arbiter still holds
  always_comb
  begin
    next_hsel_lock = hsel_lock;                   // Hold by default
    if (o_slave_ac.sel && o_slave_ac.mastlock &&
        (o_slave_ac.trans != dmem_out_pkg::HTRANS_IDLE))
    begin
      next_hsel_lock = 1'b1;                      // Locked beat to us
    end
    else if (!o_slave_ac.mastlock)
    begin
      next_hsel_lock = 1'b0;                      // Sequence over
    end
  end

  always_ff @(posedge i_hclk)
  begin
    if (!i_hresetn)
    begin
      hsel_lock <= 1'b0;
    end
    else if (i_hready)
    begin
      hsel_lock <= next_hsel_lock;                // Accepting edges only
    end
  end

  // Lock counts only when selected or already inside our sequence
  assign o_hlock_arb = o_slave_ac.mastlock & (hsel_lock | o_slave_ac.sel);

endmodule

`default_nettype wire

// ==== logic/dmem_out_data_stage.sv ====
`default_nettype none

`include "dmem_out_params.svh"

module dmem_out_data_stage (
  input  wire                                          i_hclk,       // HCLK
  input  wire                                          i_hresetn,    // HRESETn, sync
  input  wire [`DMEM_NPORTS-1:0][`DMEM_DATA_W-1:0]     i_port_wdata, // HWDATA per port
  input  dmem_out_pkg::port_idx_t                      i_grant_port, // Address owner
  input  wire                                          i_addr_sel,   // HSELM
  input  dmem_out_pkg::htrans_e                        i_addr_trans, // HTRANSM
  input  wire                                          i_hreadyoutm, // From slave
  output logic [`DMEM_DATA_W-1:0]                      o_hwdatam,    // To slave
  output logic                                         o_hready_mux  // HREADYMUXM
);

  // ------------------------------
  // Declarations
  // ------------------------------
  dmem_out_pkg::port_idx_t data_port;   // Owner of data phase
  logic                    wdata_phase; // Real transfer in data phase
  logic                    slave_sel;   // Slave owns this data phase
  logic                    addr_xfer;   // NONSEQ or SEQ to us

  assign addr_xfer = i_addr_sel &&
                     (i_addr_trans inside {dmem_out_pkg::HTRANS_NONSEQ,
                                           dmem_out_pkg::HTRANS_SEQ});

  // ------------------------------
  // Data phase registers
  // ------------------------------
  always_ff @(posedge i_hclk)
  begin
    if (!i_hresetn)
    begin
      data_port   <= dmem_out_pkg::port_idx_t'(`DMEM_RESET_DPORT);
      wdata_phase <= 1'b0;
      slave_sel   <= 1'b0;                        // Ready mux passes 1
    end
    else if (o_hready_mux)                        // Address phase accepted
    begin
      data_port   <= i_grant_port;                // Address owner moves to data
      wdata_phase <= addr_xfer;
      slave_sel   <= i_addr_sel;
    end
  end

  // ------------------------------
  // Write data mux
  // ------------------------------
  // Zero outside data phases keeps HWDATAM from toggling
  always_comb
  begin
    o_hwdatam = '0;
    if (wdata_phase)
    begin
      o_hwdatam = i_port_wdata[data_port];
    end
  end

  // ------------------------------
  // HREADYMUXM
  // ------------------------------
  // Slave drives ready only for its own data phase
  assign o_hready_mux = slave_sel ? i_hreadyoutm : 1'b1;

endmodule

`default_nettype wire

// ==== logic/dmem_out_top.sv ====
`default_nettype none

`include "dmem_out_params.svh"

module dmem_out_top (
  input  wire                                             i_hclk,       // HCLK
  input  wire                                             i_hresetn,    // HRESETn, sync
  input  dmem_out_pkg::ahb_addr_ctrl_t [`DMEM_NPORTS-1:0] i_port_ac,    // Address phases
  input  wire [`DMEM_NPORTS-1:0][`DMEM_DATA_W-1:0]        i_port_wdata, // Write data
  input  wire [`DMEM_NPORTS-1:0]                          i_held_tran,  // Held transfers
  input  wire                                             i_hreadyoutm, // Slave ready
  output logic [`DMEM_NPORTS-1:0]                         o_active,     // Port owns slave
  output dmem_out_pkg::ahb_addr_ctrl_t                    o_slave_ac,   // HSELM, HADDRM, ...
  output logic [`DMEM_DATA_W-1:0]                         o_hwdatam,    // HWDATAM
  output logic                                            o_hreadymuxm  // HREADYMUXM
);

  // ------------------------------
  // Internal wiring
  // ------------------------------
  dmem_out_pkg::port_idx_t      grant_port; // Address owner
  logic                         no_port;    // No owner
  dmem_out_pkg::ahb_addr_ctrl_t slave_ac;   // Selected bundle
  logic                         hlock_arb;  // Owner lock
  logic                         hready_mux; // Transfer done
  logic [`DMEM_NPORTS-1:0]      port_sel;   // HSEL of each port

  always_comb
  begin
    for (int p = 0; p < `DMEM_NPORTS; p++)
    begin
      port_sel[p] = i_port_ac[p].sel;             // Gather HSELs
    end
  end

  // ------------------------------
  // Stages
  // ------------------------------
  dmem_out_arbiter u_arbiter (
    .i_hclk        (i_hclk),
    .i_hresetn     (i_hresetn),
    .i_held_tran   (i_held_tran),
    .i_port_sel    (port_sel),
    .i_hready      (hready_mux),
    .i_owner_trans (slave_ac.trans),
    .i_owner_sel   (slave_ac.sel),
    .i_hlock_arb   (hlock_arb),
    .o_grant_port  (grant_port),
    .o_no_port     (no_port)
  );

  dmem_out_addr_stage u_addr_stage (
    .i_hclk       (i_hclk),
    .i_hresetn    (i_hresetn),
    .i_port_ac    (i_port_ac),
    .i_grant_port (grant_port),
    .i_no_port    (no_port),
    .i_hready     (hready_mux),
    .o_slave_ac   (slave_ac),
    .o_active     (o_active),
    .o_hlock_arb  (hlock_arb)
  );

  dmem_out_data_stage u_data_stage (
    .i_hclk       (i_hclk),
    .i_hresetn    (i_hresetn),
    .i_port_wdata (i_port_wdata),
    .i_grant_port (grant_port),
    .i_addr_sel   (slave_ac.sel),
    .i_addr_trans (slave_ac.trans),
    .i_hreadyoutm (i_hreadyoutm),
    .o_hwdatam    (o_hwdatam),
    .o_hready_mux (hready_mux)
  );

  assign o_slave_ac   = slave_ac;
  assign o_hreadymuxm = hready_mux;

endmodule

`default_nettype wire

// ==== tests/dmem_out_asserts.sv ====
`default_nettype none

`include "dmem_out_params.svh"

module dmem_out_asserts (
  input wire                      i_hclk,    // HCLK
  input wire                      i_hresetn, // HRESETn, sync
  input wire                      i_accept,  // Transfer accepted on this edge
  input dmem_out_pkg::port_idx_t  i_port,    // Registered owner
  input wire                      i_valid,   // Owner present
  input wire                      i_pinned,  // Burst beat or lock
  input wire [`DMEM_NPORTS-1:0]   i_active   // Active flag per port
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // Owner rules
  // ------------------------------
  a_stall_stable : assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    !i_accept |=> ($stable(i_port) && $stable(i_valid)))
    else $error("owner changed on an edge without an accepted transfer");

  a_owner_onehot : assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    $onehot0(i_active))
    else $error("more than one port owns the slave");

  a_pinned_hold : assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    (i_accept && i_valid && i_pinned) |=> ($stable(i_port) && i_valid))
    else $error("grant left an owner in a burst or locked sequence");

endmodule

// Grant register and active vector seen on the wiring between the stages
bind dmem_out_top dmem_out_asserts u_owner_asserts (
  .i_hclk    (i_hclk),
  .i_hresetn (i_hresetn),
  .i_accept  (hready_mux),
  .i_port    (grant_port),
  .i_valid   (!no_port),
  .i_pinned  (hlock_arb || (slave_ac.sel &&
              (slave_ac.trans == dmem_out_pkg::HTRANS_SEQ ||
               slave_ac.trans == dmem_out_pkg::HTRANS_BUSY))),
  .i_active  (o_active)
);

`default_nettype wire

// ==== tests/dmem_out_tb.sv ====
`default_nettype none

`include "dmem_out_params.svh"

module dmem_out_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NP           = `DMEM_NPORTS;
  localparam int RESET_CYCLES = 10;
  localparam int N_CYCLES     = 2000;
  localparam int MAX_CYCLES   = 2500; // Reset plus stimulus with margin

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic                                  hclk;
  logic                                  hresetn;
  dmem_out_pkg::ahb_addr_ctrl_t [NP-1:0] port_ac;
  logic [NP-1:0][`DMEM_DATA_W-1:0]       port_wdata;
  logic [NP-1:0]                         held_tran;
  logic                                  hreadyoutm;
  logic [NP-1:0]                         active;
  dmem_out_pkg::ahb_addr_ctrl_t          slave_ac;
  logic [`DMEM_DATA_W-1:0]               hwdatam;
  logic                                  hreadymuxm;

  // Reference model state
  dmem_out_pkg::port_idx_t      m_grant, m_dport, acc_owner;
  logic                         m_no_port, m_hsel_lock, m_wphase, m_ssel;
  logic                         last_accept, acc_valid;
  dmem_out_pkg::ahb_addr_ctrl_t exp_ac;
  logic [NP-1:0]                exp_active, prev_active;
  logic [`DMEM_DATA_W-1:0]      exp_wdata, prev_wdata;
  logic                         exp_ready;
  int                           beats_left [NP]; // SEQ beats still to issue
  int                           errors = 0;
  int                           checks = 0;
  int                           cycles = 0;
  integer                       seed;

  dmem_out_top i_dmem_out_top (
    .i_hclk       (hclk),
    .i_hresetn    (hresetn),
    .i_port_ac    (port_ac),
    .i_port_wdata (port_wdata),
    .i_held_tran  (held_tran),
    .i_hreadyoutm (hreadyoutm),
    .o_active     (active),
    .o_slave_ac   (slave_ac),
    .o_hwdatam    (hwdatam),
    .o_hreadymuxm (hreadymuxm)
  );

  initial
  begin
    hclk = 1'b0;
    forever #20 hclk = ~hclk;                     // 40 ns period
  end

  always @(posedge hclk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Checking
  // ------------------------------
  task automatic check_val(input logic [63:0] exp_v, input logic [63:0] act_v,
                           input string what);
    checks++;
    if (exp_v !== act_v)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %0h got %0h", $time, what, exp_v, act_v);
    end
  endtask

  task automatic compare_outputs(input bit first);
    exp_ac     = '0;
    exp_active = '0;
    if (!m_no_port)
    begin
      exp_ac              = port_ac[m_grant];
      exp_active[m_grant] = 1'b1;
    end
    exp_ready = m_ssel ? hreadyoutm : 1'b1;       // Slave owns ready only when selected
    exp_wdata = m_wphase ? port_wdata[m_dport] : '0;
    if (first)
    begin
      check_val(0, active, "o_active after reset");
      check_val(0, slave_ac.sel, "HSELM after reset");
      check_val(dmem_out_pkg::HTRANS_IDLE, slave_ac.trans, "HTRANSM after reset");
      check_val(0, hwdatam, "o_hwdatam after reset");
      check_val(1, hreadymuxm, "o_hreadymuxm after reset");
    end
    check_val(exp_active, active, "o_active grant");
    check_val(exp_ac, slave_ac, "o_slave_ac");
    check_val(exp_wdata, hwdatam, "o_hwdatam");
    check_val(exp_ready, hreadymuxm, "o_hreadymuxm");
    if (!last_accept)
    begin
      check_val(prev_active, active, "o_active during stall");
      check_val(prev_wdata, hwdatam, "o_hwdatam during stall");
    end
    prev_active = exp_active;
    prev_wdata  = exp_wdata;
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic model_step;
    logic                    lock, hold, found;
    dmem_out_pkg::port_idx_t idx;
    last_accept = exp_ready;
    acc_owner   = m_grant;
    acc_valid   = !m_no_port;
    if (exp_ready)
    begin
      lock = exp_ac.mastlock && (m_hsel_lock || exp_ac.sel);
      hold = lock || (exp_ac.sel && (exp_ac.trans == dmem_out_pkg::HTRANS_SEQ ||
                                     exp_ac.trans == dmem_out_pkg::HTRANS_BUSY));
      m_dport  = m_grant;                         // Address owner enters data phase
      m_ssel   = exp_ac.sel;
      m_wphase = exp_ac.sel && (exp_ac.trans == dmem_out_pkg::HTRANS_NONSEQ ||
                                exp_ac.trans == dmem_out_pkg::HTRANS_SEQ);
      if (exp_ac.sel && exp_ac.mastlock && exp_ac.trans != dmem_out_pkg::HTRANS_IDLE)
        m_hsel_lock = 1'b1;
      else if (!exp_ac.mastlock)
        m_hsel_lock = 1'b0;
      if (!hold)
      begin
        found = 1'b0;
        for (int k = 1; k <= NP; k++)
        begin
          idx = dmem_out_pkg::port_idx_t'((m_grant + k) % NP); // Cyclic after last grant
          if (!found && held_tran[idx] && port_ac[idx].sel)
          begin
            m_grant = idx;
            found   = 1'b1;
          end
        end
        m_no_port = !found;                       // Last grant kept for RR order
      end
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic randomize_port(input int p);
    logic [31:0] r, a;
    r = $random(seed);
    a = $random(seed);
    held_tran[p]         = r[0];
    port_ac[p].sel       = r[0] | r[1];           // Requests always select us
    port_ac[p].trans     = r[0] ? dmem_out_pkg::HTRANS_NONSEQ : dmem_out_pkg::HTRANS_IDLE;
    port_ac[p].burst     = dmem_out_pkg::hburst_e'(r[5:3]);
    port_ac[p].mastlock  = r[0] && (r[10:8] == 3'd0);
    port_ac[p].write     = r[11];
    port_ac[p].size      = 3'b010;
    port_ac[p].prot      = r[15:12];
    port_ac[p].master    = `DMEM_MASTER_W'(p);
    port_ac[p].addr      = {a[31:2], 2'b00};
    beats_left[p] = (r[0] && port_ac[p].burst != dmem_out_pkg::HBURST_SINGLE) ?
                    1 + int'(r[7:6]) : 0;
  endtask

  // Next beat of a port whose address phase was just accepted
  task automatic advance_port(input int p);
    logic [31:0] r;
    r = $random(seed);
    if (held_tran[p] && beats_left[p] > 0)
    begin
      port_ac[p].sel = 1'b1;
      if (r[1:0] == 2'b00)
        port_ac[p].trans = dmem_out_pkg::HTRANS_BUSY;
      else if (port_ac[p].mastlock && r[3:2] == 2'b00)
      begin
        port_ac[p].sel   = 1'b0;                  // Locked side access elsewhere
        port_ac[p].trans = dmem_out_pkg::HTRANS_NONSEQ;
      end
      else
      begin
        port_ac[p].trans = dmem_out_pkg::HTRANS_SEQ;
        port_ac[p].addr  = port_ac[p].addr + 32'd4;
        beats_left[p]--;
      end
    end
    else
      randomize_port(p);
  endtask

  task automatic drive_inputs;
    if (last_accept)                              // Everything holds through a stall
    begin
      for (int p = 0; p < NP; p++)
      begin
        if (acc_valid && acc_owner == p)
          advance_port(p);
        else if (!held_tran[p])
          randomize_port(p);
        else
          port_ac[p].sel = 1'b1;                  // Waiting port keeps asking
        port_wdata[p] = $random(seed);
      end
    end
    hreadyoutm = (($random(seed) & 3) != 0);      // About 75% ready
  endtask

  initial
  begin
    seed        = 32'h9e1a;
    hresetn     = 1'b0;
    port_ac     = '0;
    port_wdata  = '0;
    held_tran   = '0;
    hreadyoutm  = 1'b1;
    m_grant     = 2'd3;                           // Port 0 wins first
    m_dport     = 2'd3;
    m_no_port   = 1'b1;
    m_hsel_lock = 1'b0;
    m_wphase    = 1'b0;
    m_ssel      = 1'b0;
    last_accept = 1'b1;
    acc_owner   = '0;
    acc_valid   = 1'b0;
    for (int p = 0; p < NP; p++)
      beats_left[p] = 0;
    repeat (RESET_CYCLES) @(posedge hclk);
    #2 hresetn = 1'b1;
    for (int c = 0; c < N_CYCLES; c++)
    begin
      @(negedge hclk);
      compare_outputs(c == 0);
      @(posedge hclk);
      model_step();
      #2;
      drive_inputs();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dmem_out.f ====
+incdir+logic
logic/dmem_out_pkg.sv
logic/dmem_out_arbiter.sv
logic/dmem_out_addr_stage.sv
logic/dmem_out_data_stage.sv
logic/dmem_out_top.sv
tests/dmem_out_asserts.sv
tests/dmem_out_tb.sv
